// ==== video_pkg.sv ====
package video_pkg;

	// one dot as sent to the DAC, packed {red[1:0], green[1:0], blue[1:0]}
	typedef logic [5:0] color_t;

	// raster counter widths, wide enough for the default TV timing with room to spare
	localparam int HCOUNT_W = 10;	// horizontal position, counted in clocks
	localparam int VCOUNT_W = 9;	// vertical position, counted in TV lines

	// owner of the single video memory port in a given cycle
	typedef enum logic [1:0]
	{
		GRANT_IDLE,	// nobody asked, the port is free
		GRANT_FETCH,	// the screen fetcher took the port
		GRANT_HOST	// a pending host write went through
	} grant_t;

endpackage

// ==== vram_bus_if.sv ====
`timescale 1ns/10ps

interface vram_bus_if import video_pkg::*;
#(
	parameter int ADDR_W = 10
);

	logic [ADDR_W-1:0] addr;	// word address into the video memory
	logic rd;	// read strobe, data follows one clock later
	logic wr;	// write strobe, held until the port takes it
	color_t wdata;
	color_t rdata;	// registered read data from the port

	// the requester side drives the request
	modport master (output addr, rd, wr, wdata, input rdata);

	// the memory port answers
	modport slave (input addr, rd, wr, wdata, output rdata);

endinterface

// ==== video_sync.sv ====
`timescale 1ns/10ps

module video_sync import video_pkg::*;
#(
	parameter int H_TOTAL      = 128,
	parameter int H_ACTIVE     = 64,
	parameter int H_SYNC_START = 96,
	parameter int H_SYNC_LEN   = 8,
	parameter int V_TOTAL      = 40,
	parameter int V_ACTIVE     = 16,
	parameter int V_SYNC_START = 30,
	parameter int V_SYNC_LEN   = 2
)
(
	input  logic clk,
	input  logic reset,
	output logic hblank,
	output logic vblank,
	output logic hpix,
	output logic vpix,
	output logic hsync,
	output logic vsync,
	output logic vga_hsync,
	output logic dot_ce,
	output logic scanin_start,
	output logic scanout_start,
	output logic hsync_start
);

	logic [HCOUNT_W-1:0] hcount;
	logic [HCOUNT_W-1:0] hcount_nxt;	// position the registered decodes describe
	logic [VCOUNT_W-1:0] vcount;
	logic [VCOUNT_W-1:0] vcount_nxt;
	logic [HCOUNT_W-1:0] hhalf;	// offset inside the current half line, for VGA timing

	// next raster position, forced to the top left corner while reset is high
	always_comb
	begin
		if (reset)
		begin
			hcount_nxt = '0;
			vcount_nxt = '0;
		end
		else if (hcount == HCOUNT_W'(H_TOTAL - 1))
		begin
			hcount_nxt = '0;	// end of line, step down one line
			vcount_nxt = (vcount == VCOUNT_W'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
		end
		else
		begin
			hcount_nxt = hcount + 1'b1;
			vcount_nxt = vcount;
		end
	end

	// a VGA line is half a TV line, so fold the second half back onto the first
	assign hhalf = (hcount_nxt >= HCOUNT_W'(H_TOTAL / 2)) ?
		hcount_nxt - HCOUNT_W'(H_TOTAL / 2) : hcount_nxt;

	// every decode is taken from the next position, so each output lines up with hcount
	always_ff @(posedge clk)
	begin
		hcount <= hcount_nxt;
		vcount <= vcount_nxt;

		hpix <= hcount_nxt < HCOUNT_W'(H_ACTIVE);	// active window, horizontal
		vpix <= vcount_nxt < VCOUNT_W'(V_ACTIVE);
		hblank <= hcount_nxt >= HCOUNT_W'(H_ACTIVE + 16);	// border runs 16 clocks past the window
		vblank <= vcount_nxt >= VCOUNT_W'(V_ACTIVE + 8);

		hsync <= (hcount_nxt >= HCOUNT_W'(H_SYNC_START)) &&
			(hcount_nxt < HCOUNT_W'(H_SYNC_START + H_SYNC_LEN));
		vsync <= (vcount_nxt >= VCOUNT_W'(V_SYNC_START)) &&
			(vcount_nxt < VCOUNT_W'(V_SYNC_START + V_SYNC_LEN));

		// doubled rate sync, twice per TV line at half the width
		vga_hsync <= (hhalf >= HCOUNT_W'(H_SYNC_START / 2)) &&
			(hhalf < HCOUNT_W'(H_SYNC_START / 2 + H_SYNC_LEN / 2));

		dot_ce <= ~hcount_nxt[0];	// a TV dot spans two clocks, it starts on even counts
		hsync_start <= hcount_nxt == '0;
		scanin_start <= hcount_nxt == '0;	// doubler starts filling a new line
		scanout_start <= (hcount_nxt == '0) || (hcount_nxt == HCOUNT_W'(H_TOTAL / 2));
	end

endmodule

// ==== vram_port.sv ====
`timescale 1ns/10ps

module vram_port import video_pkg::*;
#(
	parameter int ADDR_W = 10
)
(
	input  logic clk,
	input  logic reset,
	vram_bus_if.slave fetch,
	vram_bus_if.slave host,
	output logic host_done
);

	color_t mem [2**ADDR_W];	// the video memory, one colour per word
	grant_t grant;
	grant_t grant_nxt;
	logic fetch_req;	// fetch side wants the port
	logic host_go;	// host write is performed this cycle
	logic we;
	logic [ADDR_W-1:0] port_addr;
	color_t port_wdata;
	color_t rdata_q;

	assign fetch_req = fetch.rd | fetch.wr;

	// the fetcher always wins, and the cycle right after a host write is skipped so
	// the host has time to see host_done before its held strobe is taken again
	assign host_go = host.wr & ~fetch_req & (grant != GRANT_HOST);

	// one address and one data path into the memory, steered by the winner
	assign we = fetch.wr | host_go;
	assign port_addr = fetch_req ? fetch.addr : host.addr;
	assign port_wdata = fetch_req ? fetch.wdata : host.wdata;

	always_comb
	begin
		if (fetch_req)
			grant_nxt = GRANT_FETCH;
		else if (host_go)
			grant_nxt = GRANT_HOST;
		else
			grant_nxt = GRANT_IDLE;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			grant <= GRANT_IDLE;
			host_done <= 1'b0;
		end
		else
		begin
			grant <= grant_nxt;
			host_done <= host_go;	// one clock pulse, the write is already in memory
		end
	end

	// single port, so a cycle either writes or reads
	always_ff @(posedge clk)
	begin
		if (we)
			mem[port_addr] <= port_wdata;
		else if (fetch.rd | host.rd)
			rdata_q <= mem[port_addr];	// valid on the clock after the strobe
	end

	// both sides share the read register, each reads it after its own strobe
	assign fetch.rdata = rdata_q;
	assign host.rdata = rdata_q;

endmodule

// ==== pixel_fetch.sv ====
`timescale 1ns/10ps

module pixel_fetch import video_pkg::*;
#(
	parameter int H_TOTAL  = 128,
	parameter int H_ACTIVE = 64,
	parameter int ADDR_W   = 10
)
(
	input  logic clk,
	input  logic reset,
	input  logic dot_ce,
	input  logic hpix,
	input  logic vpix,
	vram_bus_if.master bus,
	output color_t pixel
);

	localparam int DOTS = H_ACTIVE / 2;	// screen dots in one line
	localparam int LEAD = H_TOTAL - H_ACTIVE - 2;	// blank clocks before the read for dot 0

	logic [HCOUNT_W-1:0] col;	// dot index the beam is on
	logic [HCOUNT_W-1:0] blank_cnt;	// clocks since the window closed
	logic [VCOUNT_W-1:0] row;	// screen row of the next dot to be read
	logic first_rd;
	logic line_rd;
	logic rd_q;	// a read went out last clock
	logic [ADDR_W-1:0] row_base;
	logic [ADDR_W-1:0] rd_dot;

	// dot 0 of the coming line is read in the blanking of the line before, which is
	// done on every line since the next vpix is not known yet
	assign first_rd = ~hpix & dot_ce & (blank_cnt == HCOUNT_W'(LEAD));

	// inside the window each dot start reads the dot after the current one
	assign line_rd = hpix & vpix & dot_ce & (col < HCOUNT_W'(DOTS - 1));

	assign row_base = ADDR_W'(row) * ADDR_W'(DOTS);
	assign rd_dot = first_rd ? '0 : ADDR_W'(col + 1'b1);

	assign bus.addr = row_base + rd_dot;
	assign bus.rd = first_rd | line_rd;
	assign bus.wr = 1'b0;	// the fetcher only reads
	assign bus.wdata = '0;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			col <= '0;
			blank_cnt <= '0;
			row <= '0;
			rd_q <= 1'b0;
			pixel <= '0;
		end
		else
		begin
			rd_q <= bus.rd;
			if (rd_q)
				pixel <= bus.rdata;	// held for both clocks of the dot

			// dot index runs with the window, the blank counter runs outside it
			if (hpix)
			begin
				blank_cnt <= '0;
				if (dot_ce)
					col <= col + 1'b1;
			end
			else
			begin
				blank_cnt <= blank_cnt + 1'b1;
				col <= '0;
			end

			// rows count up at each window end and restart while vpix is low
			if (!vpix)
				row <= '0;
			else if (!hpix && (blank_cnt == '0))
				row <= row + 1'b1;
		end
	end

endmodule

// ==== vga_double.sv ====
`timescale 1ns/10ps

module vga_double import video_pkg::*;
#(
	parameter int H_TOTAL  = 128,
	parameter int H_ACTIVE = 64
)
(
	input  logic clk,
	input  logic hsync_start,
	input  logic scanin_start,
	input  logic scanout_start,
	input  color_t pix_in,
	output color_t pix_out
);

	localparam int IDX_W = $clog2(H_ACTIVE);
	localparam int PTR_W = IDX_W + 1;	// one more bit so a pointer can stop at the end

	// a VGA line lasts half a TV line, so never read more than fits into it
	localparam int RD_LEN = (H_TOTAL / 2 < H_ACTIVE) ? H_TOTAL / 2 : H_ACTIVE;

	color_t line_buf [2][H_ACTIVE];	// ping-pong pair, one filled while the other plays
	logic sel = 1'b0;	// buffer taking writes
	logic wsel;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wa;
	logic [PTR_W-1:0] ra;

	// the swap takes effect in the strobe cycle itself, so hcount 0 lands in the new line
	assign wsel = sel ^ hsync_start;

	// pointers rewind on their strobes without losing a clock
	assign wa = scanin_start ? '0 : wr_ptr;
	assign ra = scanout_start ? '0 : rd_ptr;

	always_ff @(posedge clk)
	begin
		sel <= wsel;

		// every clock is written, so each TV dot fills two entries
		if (wa < PTR_W'(H_ACTIVE))
		begin
			line_buf[wsel][wa[IDX_W-1:0]] <= pix_in;
			wr_ptr <= wa + 1'b1;
		end

		// one entry per clock on the way out, this doubles the dot rate
		if (ra < PTR_W'(RD_LEN))
			rd_ptr <= ra + 1'b1;
	end

	// black once the stored line has run out
	assign pix_out = (ra < PTR_W'(RD_LEN)) ? line_buf[~wsel][ra[IDX_W-1:0]] : '0;

endmodule

// ==== videoout.sv ====
`timescale 1ns/10ps

module videoout import video_pkg::*;
#(
	parameter int H_TOTAL  = 128,
	parameter int H_ACTIVE = 64
)
(
	input  logic clk,
	input  logic reset,
	input  logic hblank,
	input  logic vblank,
	input  logic hpix,
	input  logic vpix,
	input  logic hsync,
	input  logic vsync,
	input  logic vga_hsync,
	input  logic spx_en,
	input  logic zxg_en,
	input  logic cfg_vga_on,
	input  logic scanin_start,
	input  logic scanout_start,
	input  logic hsync_start,
	input  color_t pixel,
	input  color_t spixel,
	input  color_t border,
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu,
	output logic vhsync,
	output logic vvsync,
	output logic vcsync
);

	color_t color;	// mixed dot at TV rate
	color_t vga_color;	// same dots after line doubling
	color_t out_color;
	logic hs_sel;

	// blanking beats everything, then the sprite, then the screen, then the border
	assign color = (hblank | vblank) ? '0 :
		spx_en ? spixel :
		(hpix & vpix & zxg_en) ? pixel : border;

	vga_double #(
		.H_TOTAL  (H_TOTAL),
		.H_ACTIVE (H_ACTIVE)
	) vga_double (
		.clk           (clk),
		.hsync_start   (hsync_start),
		.scanin_start  (scanin_start),
		.scanout_start (scanout_start),
		.pix_in        (color),
		.pix_out       (vga_color)
	);

	assign out_color = cfg_vga_on ? vga_color : color;
	assign hs_sel = cfg_vga_on ? vga_hsync : hsync;	// VGA mode needs the doubled line sync

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			vred <= '0;
			vgrn <= '0;
			vblu <= '0;
			vhsync <= 1'b0;
			vvsync <= 1'b0;
			vcsync <= 1'b1;	// both syncs idle low
		end
		else
		begin
			vred <= out_color[5:4];
			vgrn <= out_color[3:2];
			vblu <= out_color[1:0];
			vhsync <= hs_sel;
			vvsync <= vsync;
			vcsync <= ~(hs_sel ^ vsync);	// composite from the line sync actually sent
		end
	end

endmodule

// ==== video_top.sv ====
`timescale 1ns/10ps

module video_top import video_pkg::*;
#(
	parameter int H_TOTAL      = 128,
	parameter int H_ACTIVE     = 64,
	parameter int H_SYNC_START = 96,
	parameter int H_SYNC_LEN   = 8,
	parameter int V_TOTAL      = 40,
	parameter int V_ACTIVE     = 16,
	parameter int V_SYNC_START = 30,
	parameter int V_SYNC_LEN   = 2,
	parameter int ADDR_W       = 10
)
(
	input  logic clk,
	input  logic reset,
	input  logic cfg_vga_on,	// high selects line doubled VGA output
	input  logic spx_en,
	input  logic zxg_en,
	input  color_t spixel,
	input  color_t border,
	input  logic host_wr,	// held with address and data until host_done
	input  logic [ADDR_W-1:0] host_addr,
	input  color_t host_data,
	output logic host_done,
	output logic [1:0] vred,
	output logic [1:0] vgrn,
	output logic [1:0] vblu,
	output logic vhsync,
	output logic vvsync,
	output logic vcsync
);

	logic hblank;
	logic vblank;
	logic hpix;
	logic vpix;
	logic hsync;
	logic vsync;
	logic vga_hsync;
	logic dot_ce;
	logic scanin_start;
	logic scanout_start;
	logic hsync_start;
	color_t pixel;	// screen dot under the beam

	vram_bus_if #(.ADDR_W(ADDR_W)) fetch_bus ();
	vram_bus_if #(.ADDR_W(ADDR_W)) host_bus ();

	// host side only writes, its read path stays idle
	assign host_bus.addr = host_addr;
	assign host_bus.rd = 1'b0;
	assign host_bus.wr = host_wr;
	assign host_bus.wdata = host_data;

	video_sync #(
		.H_TOTAL      (H_TOTAL),
		.H_ACTIVE     (H_ACTIVE),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_LEN   (H_SYNC_LEN),
		.V_TOTAL      (V_TOTAL),
		.V_ACTIVE     (V_ACTIVE),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_LEN   (V_SYNC_LEN)
	) video_sync (.*);

	vram_port #(.ADDR_W(ADDR_W)) vram_port (
		.clk       (clk),
		.reset     (reset),
		.fetch     (fetch_bus.slave),
		.host      (host_bus.slave),
		.host_done (host_done)
	);

	pixel_fetch #(
		.H_TOTAL  (H_TOTAL),
		.H_ACTIVE (H_ACTIVE),
		.ADDR_W   (ADDR_W)
	) pixel_fetch (
		.clk    (clk),
		.reset  (reset),
		.dot_ce (dot_ce),
		.hpix   (hpix),
		.vpix   (vpix),
		.bus    (fetch_bus.master),
		.pixel  (pixel)
	);

	videoout #(
		.H_TOTAL  (H_TOTAL),
		.H_ACTIVE (H_ACTIVE)
	) videoout (.*);

endmodule

// ==== video_sva.sv ====
`timescale 1ns/10ps

module video_sva import video_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic fetch_req,	// fetcher wants the memory port
	input logic host_wr,	// held host write strobe
	input logic host_done,
	input grant_t grant,	// owner of the port in the clock before
	input logic hsync,
	input logic hpix
);

	// one requester per cycle on the single port, a host grant needs a clock the fetcher left free
	single_owner: assert property (@(posedge clk) disable iff (reset)
		(grant == GRANT_HOST) |-> $past(!fetch_req))
		else $error("fetch and host write were both granted in one cycle");

	// a done pulse needs a held write that the fetcher left alone
	done_after_write: assert property (@(posedge clk) disable iff (reset)
		host_done |-> $past(host_wr && !fetch_req))
		else $error("host_done without a pending host write");

	sync_outside_window: assert property (@(posedge clk) disable iff (reset)
		!(hsync && hpix))
		else $error("horizontal sync inside the active window");

endmodule

// ==== tb_video.sv ====
`timescale 1ns/10ps

module tb_video import video_pkg::*;
();

	localparam int H_TOTAL      = 128;
	localparam int H_ACTIVE     = 64;
	localparam int H_SYNC_START = 96;
	localparam int H_SYNC_LEN   = 8;
	localparam int V_TOTAL      = 40;
	localparam int V_ACTIVE     = 16;
	localparam int V_SYNC_START = 30;
	localparam int V_SYNC_LEN   = 2;
	localparam int ADDR_W       = 10;
	localparam int DOTS = H_ACTIVE / 2;	// a TV dot lasts two clocks
	localparam int SCREEN_WORDS = DOTS * V_ACTIVE;	// words the fetcher actually shows
	localparam int FRAME = H_TOTAL * V_TOTAL;
	localparam int WRITE_TIMEOUT = 64;	// the fetcher never holds the port for more than a few clocks

	logic clk;
	logic reset;
	logic cfg_vga_on;
	logic spx_en;
	logic zxg_en;
	color_t spixel;
	color_t border;
	logic host_wr;
	logic [ADDR_W-1:0] host_addr;
	color_t host_data;
	logic host_done;
	logic [1:0] vred;
	logic [1:0] vgrn;
	logic [1:0] vblu;
	logic vhsync;
	logic vvsync;
	logic vcsync;

	integer seed;
	int checks = 0;
	int mismatches = 0;
	int failures = 0;	// anything that is not a wrong output value
	int hc;	// beam position shown by the DUT decodes before the next edge
	int vc;
	logic model_valid = 1'b0;
	logic wr_prev = 1'b0;	// host_wr as seen at the last falling edge
	logic done_prev = 1'b0;	// host_done as seen at the last falling edge
	logic [8:0] expected;	// {colour, hsync, vsync, csync} due after the last edge
	color_t screen_mem [2**ADDR_W];	// the host's own copy of the video memory
	color_t cur_line [H_ACTIVE];	// TV line being captured for doubling
	color_t prev_line [H_ACTIVE];	// the line the doubler plays back twice

	video_top #(
		.H_TOTAL      (H_TOTAL),
		.H_ACTIVE     (H_ACTIVE),
		.H_SYNC_START (H_SYNC_START),
		.H_SYNC_LEN   (H_SYNC_LEN),
		.V_TOTAL      (V_TOTAL),
		.V_ACTIVE     (V_ACTIVE),
		.V_SYNC_START (V_SYNC_START),
		.V_SYNC_LEN   (V_SYNC_LEN),
		.ADDR_W       (ADDR_W)
	) i_dut (.*);

	// arbitration rules are checked inside the memory port
	bind vram_port video_sva arb_checks (
		.clk       (clk),
		.reset     (reset),
		.fetch_req (fetch_req),
		.host_wr   (host.wr),
		.host_done (host_done),
		.grant     (grant),
		.hsync     (1'b0),
		.hpix      (1'b0)
	);

	// raster rules are checked inside the sync generator
	bind video_sync video_sva sync_checks (
		.clk       (clk),
		.reset     (reset),
		.fetch_req (1'b0),
		.host_wr   (1'b0),
		.host_done (1'b0),
		.grant     (GRANT_IDLE),
		.hsync     (hsync),
		.hpix      (hpix)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// colour at TV rate, blanking first, then sprite, then screen, then border
	function automatic color_t mix_color(int h, int v, logic spx, logic zxg, color_t spx_dot,
		color_t brd);
		if ((h >= H_ACTIVE + 16) || (v >= V_ACTIVE + 8))
			return '0;
		else if (spx)
			return spx_dot;
		else if ((h < H_ACTIVE) && (v < V_ACTIVE) && zxg)
			return screen_mem[v * DOTS + h / 2];	// read two clocks ahead, shown for both clocks
		else
			return brd;
	endfunction

	// outputs due for one beam position, with the sync picked by the mode
	function automatic logic [8:0] expected_out(int h, int v, logic vga, color_t tv, color_t dbl);
		int hh;
		logic hs;
		logic vs;
		hh = (h >= H_TOTAL / 2) ? h - H_TOTAL / 2 : h;	// position inside the VGA line
		if (vga)
			hs = (hh >= H_SYNC_START / 2) && (hh < H_SYNC_START / 2 + H_SYNC_LEN / 2);
		else
			hs = (h >= H_SYNC_START) && (h < H_SYNC_START + H_SYNC_LEN);
		vs = (v >= V_SYNC_START) && (v < V_SYNC_START + V_SYNC_LEN);
		return {vga ? dbl : tv, hs, vs, ~(hs ^ vs)};
	endfunction

	function automatic color_t random_color();
		return color_t'($random(seed));
	endfunction

	task automatic compare_signal(input string name, input logic [5:0] got,
		input logic [5:0] want);
		assert (got === want)
		else
		begin
			mismatches++;
			$display("Mismatch at %0t: %s is %0h, expected %0h", $time, name, got, want);
		end
	endtask

	// one host write, held until the port answers with host_done
	task automatic write_word(input logic [ADDR_W-1:0] addr, input color_t data);
		int waited;
		logic done_seen;
		waited = 0;
		done_seen = 1'b0;
		@(posedge clk);
		host_wr <= 1'b1;
		host_addr <= addr;
		host_data <= data;
		while (!done_seen && (waited < WRITE_TIMEOUT))
		begin
			@(negedge clk);
			done_seen = host_done;
			waited++;
		end
		assert (done_seen)
		else
		begin
			failures++;
			$display("host write to address %0d was not done within %0d clocks", addr,
				WRITE_TIMEOUT);
		end
		if (done_seen)
			screen_mem[addr] = data;
		@(posedge clk);
		host_wr <= 1'b0;	// the port skips the clock after a write, so one pulse only
	endtask

	// writes count words, in order from zero or at random screen addresses
	task automatic load_words(input int count, input bit in_order);
		logic [ADDR_W-1:0] addr;
		for (int i = 0; i < count; i++)
		begin
			addr = in_order ? ADDR_W'(i) : ADDR_W'($unsigned($random(seed)) % SCREEN_WORDS);
			write_word(addr, random_color());
		end
		repeat (4) @(posedge clk);	// reads already in flight still carry the old data
	endtask

	task automatic run_cycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	// sprite enable flickers with a new sprite colour on every clock
	task automatic sprite_noise(input int count);
		repeat (count)
		begin
			@(posedge clk);
			spx_en <= (($random(seed) & 3) == 0);
			spixel <= random_color();
		end
		@(posedge clk);
		spx_en <= 1'b0;
	endtask

	// reference model, steps the beam and the doubler line on every edge
	always @(posedge clk)
	begin : model_step
		color_t tv;
		int hh;
		if (reset)
		begin
			expected = 9'b000000_0_0_1;	// black, syncs idle, csync high
			hc = 0;
			vc = 0;
		end
		else
		begin
			if (hc == 0)
				prev_line = cur_line;	// the doubler swaps buffers at line start
			hh = (hc >= H_TOTAL / 2) ? hc - H_TOTAL / 2 : hc;
			tv = mix_color(hc, vc, spx_en, zxg_en, spixel, border);
			expected = expected_out(hc, vc, cfg_vga_on, tv, prev_line[hh]);
			if (hc < H_ACTIVE)
				cur_line[hc] = tv;
			if (hc == H_TOTAL - 1)
			begin
				hc = 0;
				vc = (vc == V_TOTAL - 1) ? 0 : vc + 1;
			end
			else
				hc = hc + 1;
		end
		model_valid = 1'b1;
	end

	// outputs are settled at the falling edge
	always @(negedge clk)
	begin
		if (model_valid)
		begin
			checks++;
			compare_signal("vred", vred, expected[8:7]);
			compare_signal("vgrn", vgrn, expected[6:5]);
			compare_signal("vblu", vblu, expected[4:3]);
			compare_signal("vhsync", vhsync, expected[2]);
			compare_signal("vvsync", vvsync, expected[1]);
			compare_signal("vcsync", vcsync, expected[0]);
			// host_done only answers a write held in the clock before, and lasts one clock
			if (!wr_prev || done_prev)
				compare_signal("host_done", host_done, 1'b0);
		end
		wr_prev = host_wr;
		done_prev = host_done;
	end

	initial
	begin
		seed = 32'hc9e5c773;
		reset = 1'b1;
		cfg_vga_on = 1'b0;
		spx_en = 1'b0;
		zxg_en = 1'b0;
		spixel = '0;
		border = 6'b01_00_10;
		host_wr = 1'b0;
		host_addr = '0;
		host_data = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;

		load_words(SCREEN_WORDS, 1'b1);	// the fetch runs all along, only the border is shown
		zxg_en <= 1'b1;
		run_cycles(2 * FRAME);
		sprite_noise(3000);

		// graphics off, the window shows the border
		zxg_en <= 1'b0;
		border <= random_color();
		run_cycles(FRAME);
		load_words(40, 1'b0);
		zxg_en <= 1'b1;
		run_cycles(FRAME);

		// line doubled output, then back to TV rate
		cfg_vga_on <= 1'b1;
		run_cycles(2 * FRAME);
		sprite_noise(2000);
		cfg_vga_on <= 1'b0;
		run_cycles(FRAME / 2);

		$display("checked %0d clocks, %0d mismatches, %0d other errors", checks, mismatches,
			failures);
		if ((mismatches == 0) && (failures == 0))
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== list.f ====
video_pkg.sv
vram_bus_if.sv
video_sync.sv
vram_port.sv
pixel_fetch.sv
vga_double.sv
videoout.sv
video_top.sv
video_sva.sv
tb_video.sv

// ==== Bender.yml ====
package:
  name: video_out

sources:
  - video_pkg.sv
  - vram_bus_if.sv
  - video_sync.sv
  - vram_port.sv
  - pixel_fetch.sv
  - vga_double.sv
  - videoout.sv
  - video_top.sv
  - target: simulation
    files:
      - video_sva.sv
      - tb_video.sv
